//--- src/fp_dec_pkg.sv
`default_nettype none

package fp_dec_pkg;

  ////////////////////////////////////////////////////////////
  // Field types
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] instr_t;    // Raw instruction word
  typedef logic [4:0]  reg_idx_t;  // rs1, rs2, rs3 or rd
  typedef logic [6:0]  funct7_t;
  typedef logic [2:0]  rm_t;       // Rounding mode, doubles as funct3

  localparam bit HAS_DOUBLE = 1'b1;  // D extension built in

  localparam rm_t RM_RSV5 = 3'b101;
  localparam rm_t RM_RSV6 = 3'b110;
  localparam rm_t RM_DYN  = 3'b111;  // Mode comes from frm CSR

  typedef enum logic [6:0] {
    OPCODE_LOAD_FP  = 7'h07,
    OPCODE_STORE_FP = 7'h27,
    OPCODE_MADD_FP  = 7'h43,
    OPCODE_MSUB_FP  = 7'h47,
    OPCODE_NMSUB_FP = 7'h4b,
    OPCODE_NMADD_FP = 7'h4f,
    OPCODE_OP_FP    = 7'h53
  } opcode_e;

  // FPU operation groups refined by the modifier bit
  typedef enum logic [3:0] {
    FMADD, FNMSUB, ADD, MUL, DIV, SQRT, SGNJ,
    MINMAX, CMP, CLASSIFY, F2F, F2I, I2F
  } fp_op_e;

  typedef enum logic {FMT_FP32 = 1'b0, FMT_FP64 = 1'b1} fp_fmt_e;

  typedef enum logic {IMM_I = 1'b0, IMM_S = 1'b1} mem_imm_e;

  ////////////////////////////////////////////////////////////
  // OP-FP funct7 codes
  ////////////////////////////////////////////////////////////

  localparam funct7_t F7_FADD_S   = 7'b0000000;
  localparam funct7_t F7_FADD_D   = 7'b0000001;
  localparam funct7_t F7_FSUB_S   = 7'b0000100;
  localparam funct7_t F7_FSUB_D   = 7'b0000101;
  localparam funct7_t F7_FMUL_S   = 7'b0001000;
  localparam funct7_t F7_FMUL_D   = 7'b0001001;
  localparam funct7_t F7_FDIV_S   = 7'b0001100;
  localparam funct7_t F7_FDIV_D   = 7'b0001101;
  localparam funct7_t F7_FSQRT_S  = 7'b0101100;
  localparam funct7_t F7_FSQRT_D  = 7'b0101101;
  localparam funct7_t F7_FSGNJ_S  = 7'b0010000;
  localparam funct7_t F7_FSGNJ_D  = 7'b0010001;
  localparam funct7_t F7_FMINMAX_S = 7'b0010100;
  localparam funct7_t F7_FMINMAX_D = 7'b0010101;
  localparam funct7_t F7_FCMP_S   = 7'b1010000;
  localparam funct7_t F7_FCMP_D   = 7'b1010001;
  localparam funct7_t F7_F2F_S    = 7'b0100000;  // FCVT.S.D
  localparam funct7_t F7_F2F_D    = 7'b0100001;  // FCVT.D.S
  localparam funct7_t F7_F2I_S    = 7'b1100000;  // FCVT.W[U].S
  localparam funct7_t F7_F2I_D    = 7'b1100001;  // FCVT.W[U].D
  localparam funct7_t F7_I2F_S    = 7'b1101000;  // FCVT.S.W[U]
  localparam funct7_t F7_I2F_D    = 7'b1101001;  // FCVT.D.W[U]
  localparam funct7_t F7_FMVX_S   = 7'b1110000;  // FMV.X.W and FCLASS.S
  localparam funct7_t F7_FCLASS_D = 7'b1110001;
  localparam funct7_t F7_FMVW_S   = 7'b1111000;  // FMV.W.X

endpackage

`default_nettype wire

//--- src/fp_instr_capture.sv
`default_nettype none

module fp_instr_capture (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               instr_valid_i,
  input  fp_dec_pkg::instr_t instr_i,
  output fp_dec_pkg::instr_t instr_o,
  output logic               instr_valid_o
);

  fp_dec_pkg::instr_t instr_q;
  logic               valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid_i;  // Strobe delayed one cycle
    end
  end

  // Word holds until the next strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      instr_q <= instr_i;
    end
  end

  assign instr_o       = instr_q;
  assign instr_valid_o = valid_q;

endmodule

`default_nettype wire

//--- src/fp_operation_decode.sv
`default_nettype none

module fp_operation_decode (
  input  fp_dec_pkg::instr_t   instr_i,
  output fp_dec_pkg::fp_op_e   fp_op_o,
  output logic                 fp_op_mod_o,
  output fp_dec_pkg::fp_fmt_e  fmt_o,
  output logic                 swap_operands_o,
  output logic                 mv_instr_o,
  output logic                 fp_load_o,
  output logic                 fp_store_o,
  output fp_dec_pkg::mem_imm_e mem_imm_sel_o,
  output logic                 rm_dynamic_o
);

  fp_dec_pkg::opcode_e opcode;
  fp_dec_pkg::funct7_t funct7;
  fp_dec_pkg::rm_t     funct3;
  fp_dec_pkg::fp_fmt_e mem_fmt;

  assign opcode       = fp_dec_pkg::opcode_e'(instr_i[6:0]);
  assign funct7       = instr_i[31:25];
  assign funct3       = instr_i[14:12];
  assign rm_dynamic_o = (funct3 == fp_dec_pkg::RM_DYN);
  assign mem_fmt      = (funct3 == 3'b011) ? fp_dec_pkg::FMT_FP64 : fp_dec_pkg::FMT_FP32;

  always_comb begin
    fp_op_o         = fp_dec_pkg::FMADD;
    fp_op_mod_o     = 1'b0;
    fmt_o           = fp_dec_pkg::fp_fmt_e'(instr_i[25]);  // LSB of fmt field
    swap_operands_o = 1'b0;
    mv_instr_o      = 1'b0;
    fp_load_o       = 1'b0;
    fp_store_o      = 1'b0;
    mem_imm_sel_o   = fp_dec_pkg::IMM_I;

    unique case (opcode)
      fp_dec_pkg::OPCODE_LOAD_FP: begin
        fp_load_o = 1'b1;
        fmt_o     = mem_fmt;
      end
      fp_dec_pkg::OPCODE_STORE_FP: begin
        fp_store_o    = 1'b1;
        fmt_o         = mem_fmt;
        mem_imm_sel_o = fp_dec_pkg::IMM_S;  // Split store offset
      end
      fp_dec_pkg::OPCODE_MSUB_FP: begin
        fp_op_mod_o = 1'b1;
      end
      fp_dec_pkg::OPCODE_NMSUB_FP: begin
        fp_op_o = fp_dec_pkg::FNMSUB;
      end
      fp_dec_pkg::OPCODE_NMADD_FP: begin
        fp_op_o     = fp_dec_pkg::FNMSUB;
        fp_op_mod_o = 1'b1;
      end

      ////////////////////////////////////////////////////////////
      // OP-FP sub-decode on funct7
      ////////////////////////////////////////////////////////////
      fp_dec_pkg::OPCODE_OP_FP: begin
        unique case (funct7)
          fp_dec_pkg::F7_FADD_S, fp_dec_pkg::F7_FADD_D: begin
            fp_op_o         = fp_dec_pkg::ADD;
            swap_operands_o = 1'b1;  // Addend rides on operand c
          end
          fp_dec_pkg::F7_FSUB_S, fp_dec_pkg::F7_FSUB_D: begin
            fp_op_o         = fp_dec_pkg::ADD;
            fp_op_mod_o     = 1'b1;
            swap_operands_o = 1'b1;
          end
          fp_dec_pkg::F7_FMUL_S, fp_dec_pkg::F7_FMUL_D:       fp_op_o = fp_dec_pkg::MUL;
          fp_dec_pkg::F7_FDIV_S, fp_dec_pkg::F7_FDIV_D:       fp_op_o = fp_dec_pkg::DIV;
          fp_dec_pkg::F7_FSQRT_S, fp_dec_pkg::F7_FSQRT_D:     fp_op_o = fp_dec_pkg::SQRT;
          fp_dec_pkg::F7_FSGNJ_S, fp_dec_pkg::F7_FSGNJ_D:     fp_op_o = fp_dec_pkg::SGNJ;
          fp_dec_pkg::F7_FMINMAX_S, fp_dec_pkg::F7_FMINMAX_D: fp_op_o = fp_dec_pkg::MINMAX;
          fp_dec_pkg::F7_FCMP_S, fp_dec_pkg::F7_FCMP_D:       fp_op_o = fp_dec_pkg::CMP;
          fp_dec_pkg::F7_F2F_S, fp_dec_pkg::F7_F2F_D: begin
            fp_op_o = fp_dec_pkg::F2F;
            fmt_o   = fp_dec_pkg::fp_fmt_e'(instr_i[20]);  // Source format sits in rs2
          end
          fp_dec_pkg::F7_F2I_S, fp_dec_pkg::F7_F2I_D: begin
            fp_op_o     = fp_dec_pkg::F2I;
            fp_op_mod_o = instr_i[20];  // Unsigned variant
          end
          fp_dec_pkg::F7_I2F_S, fp_dec_pkg::F7_I2F_D: begin
            fp_op_o     = fp_dec_pkg::I2F;
            fp_op_mod_o = instr_i[20];
          end
          fp_dec_pkg::F7_FMVX_S: begin
            if (funct3 == 3'b001) begin
              fp_op_o = fp_dec_pkg::CLASSIFY;
            end else begin
              mv_instr_o = (funct3 == 3'b000);  // FMV.X.W
            end
          end
          fp_dec_pkg::F7_FCLASS_D: fp_op_o = fp_dec_pkg::CLASSIFY;
          fp_dec_pkg::F7_FMVW_S:   mv_instr_o = 1'b1;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/fp_legality_decode.sv
`default_nettype none

module fp_legality_decode (
  input  fp_dec_pkg::instr_t  instr_i,
  input  fp_dec_pkg::fp_fmt_e fmt_i,
  output logic                illegal_o,
  output logic                use_rs1_o,
  output logic                use_rs2_o,
  output logic                use_rs3_o,
  output logic                use_rd_o,
  output logic                fp_rf_we_o,
  output logic                int_rf_we_o
);

  fp_dec_pkg::opcode_e opcode;
  fp_dec_pkg::funct7_t funct7;
  fp_dec_pkg::rm_t     rm;
  logic                rm_bad;
  logic                rs2_nz;
  logic                cvt_bad;

  assign opcode  = fp_dec_pkg::opcode_e'(instr_i[6:0]);
  assign funct7  = instr_i[31:25];
  assign rm      = instr_i[14:12];
  assign rm_bad  = (rm == fp_dec_pkg::RM_RSV5) || (rm == fp_dec_pkg::RM_RSV6);
  assign rs2_nz  = |instr_i[24:20];
  assign cvt_bad = rm_bad || (|instr_i[24:21]);  // Only rs2[0] selects a variant

  always_comb begin
    illegal_o   = 1'b0;
    use_rs1_o   = 1'b0;
    use_rs2_o   = 1'b0;
    use_rs3_o   = 1'b0;
    use_rd_o    = 1'b0;
    fp_rf_we_o  = 1'b0;
    int_rf_we_o = 1'b0;

    unique case (opcode)
      fp_dec_pkg::OPCODE_LOAD_FP: begin
        use_rd_o   = 1'b1;
        fp_rf_we_o = 1'b1;
        illegal_o  = (rm != 3'b010) && (rm != 3'b011);  // FLW or FLD only
      end
      fp_dec_pkg::OPCODE_STORE_FP: begin
        use_rs2_o = 1'b1;  // Store data
        illegal_o = (rm != 3'b010) && (rm != 3'b011);
      end
      fp_dec_pkg::OPCODE_MADD_FP, fp_dec_pkg::OPCODE_MSUB_FP,
      fp_dec_pkg::OPCODE_NMSUB_FP, fp_dec_pkg::OPCODE_NMADD_FP: begin
        use_rs1_o  = 1'b1;
        use_rs2_o  = 1'b1;
        use_rs3_o  = 1'b1;
        use_rd_o   = 1'b1;
        fp_rf_we_o = 1'b1;
        illegal_o  = rm_bad || instr_i[26];  // fmt 10 and 11 not supported
      end

      ////////////////////////////////////////////////////////////
      // OP-FP field rules
      ////////////////////////////////////////////////////////////
      fp_dec_pkg::OPCODE_OP_FP: begin
        unique case (funct7)
          fp_dec_pkg::F7_FADD_S, fp_dec_pkg::F7_FADD_D,
          fp_dec_pkg::F7_FSUB_S, fp_dec_pkg::F7_FSUB_D,
          fp_dec_pkg::F7_FMUL_S, fp_dec_pkg::F7_FMUL_D,
          fp_dec_pkg::F7_FDIV_S, fp_dec_pkg::F7_FDIV_D: begin
            use_rs1_o  = 1'b1;
            use_rs2_o  = 1'b1;
            use_rd_o   = 1'b1;
            fp_rf_we_o = 1'b1;
            illegal_o  = rm_bad;
          end
          fp_dec_pkg::F7_FSQRT_S, fp_dec_pkg::F7_FSQRT_D: begin
            use_rs1_o  = 1'b1;
            use_rd_o   = 1'b1;
            fp_rf_we_o = 1'b1;
            illegal_o  = rm_bad || rs2_nz;
          end
          fp_dec_pkg::F7_FSGNJ_S, fp_dec_pkg::F7_FSGNJ_D,
          fp_dec_pkg::F7_FMINMAX_S, fp_dec_pkg::F7_FMINMAX_D: begin
            use_rs1_o  = 1'b1;
            use_rs2_o  = 1'b1;
            use_rd_o   = 1'b1;
            fp_rf_we_o = 1'b1;
            illegal_o  = instr_i[27] ? (rm > 3'b001) : (rm > 3'b010);  // MINMAX vs SGNJ
          end
          fp_dec_pkg::F7_FCMP_S, fp_dec_pkg::F7_FCMP_D: begin
            use_rs1_o   = 1'b1;
            use_rs2_o   = 1'b1;
            int_rf_we_o = 1'b1;
            illegal_o   = (rm > 3'b010);  // FLE, FLT, FEQ
          end
          fp_dec_pkg::F7_F2F_S, fp_dec_pkg::F7_F2F_D: begin
            use_rs1_o  = 1'b1;
            use_rd_o   = 1'b1;
            fp_rf_we_o = 1'b1;
            illegal_o  = cvt_bad;
          end
          fp_dec_pkg::F7_F2I_S, fp_dec_pkg::F7_F2I_D: begin
            use_rs1_o   = 1'b1;
            int_rf_we_o = 1'b1;
            illegal_o   = cvt_bad;
          end
          fp_dec_pkg::F7_I2F_S, fp_dec_pkg::F7_I2F_D: begin
            use_rd_o   = 1'b1;
            fp_rf_we_o = 1'b1;  // Both widths land in the FP file
            illegal_o  = cvt_bad;
          end
          fp_dec_pkg::F7_FMVX_S: begin
            use_rs1_o   = 1'b1;
            int_rf_we_o = 1'b1;
            illegal_o   = rs2_nz || (rm > 3'b001);  // FMV.X.W 000, FCLASS.S 001
          end
          fp_dec_pkg::F7_FCLASS_D: begin
            use_rs1_o   = 1'b1;
            int_rf_we_o = 1'b1;
            illegal_o   = rs2_nz || (rm != 3'b001);
          end
          fp_dec_pkg::F7_FMVW_S: begin
            use_rd_o   = 1'b1;
            fp_rf_we_o = 1'b1;
            illegal_o  = rs2_nz || (|rm);
          end
          default: illegal_o = 1'b1;
        endcase
      end
      default: illegal_o = 1'b1;
    endcase

    if (!fp_dec_pkg::HAS_DOUBLE && (fmt_i == fp_dec_pkg::FMT_FP64)) begin
      illegal_o = 1'b1;  // No D support
    end
  end

endmodule

`default_nettype wire

//--- src/fp_decode_reg.sv
`default_nettype none

module fp_decode_reg (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  logic                 illegal_i,
  input  fp_dec_pkg::reg_idx_t rs1_i,
  input  fp_dec_pkg::reg_idx_t rs2_i,
  input  fp_dec_pkg::reg_idx_t rs3_i,
  input  fp_dec_pkg::reg_idx_t rd_i,
  input  fp_dec_pkg::rm_t      rounding_mode_i,
  input  logic                 rm_dynamic_i,
  input  logic                 use_rs1_i,
  input  logic                 use_rs2_i,
  input  logic                 use_rs3_i,
  input  logic                 use_rd_i,
  input  logic                 fp_rf_we_i,
  input  logic                 int_rf_we_i,
  input  fp_dec_pkg::fp_op_e   fp_op_i,
  input  logic                 fp_op_mod_i,
  input  fp_dec_pkg::fp_fmt_e  fmt_i,
  input  logic                 swap_operands_i,
  input  logic                 mv_instr_i,
  input  logic                 fp_load_i,
  input  logic                 fp_store_i,
  input  fp_dec_pkg::mem_imm_e mem_imm_sel_i,
  output logic                 dec_valid_o,
  output logic                 illegal_o,
  output fp_dec_pkg::reg_idx_t rs1_o,
  output fp_dec_pkg::reg_idx_t rs2_o,
  output fp_dec_pkg::reg_idx_t rs3_o,
  output fp_dec_pkg::reg_idx_t rd_o,
  output fp_dec_pkg::rm_t      rounding_mode_o,
  output logic                 rm_dynamic_o,
  output logic                 use_rs1_o,
  output logic                 use_rs2_o,
  output logic                 use_rs3_o,
  output logic                 use_rd_o,
  output logic                 fp_rf_we_o,
  output logic                 int_rf_we_o,
  output fp_dec_pkg::fp_op_e   fp_op_o,
  output logic                 fp_op_mod_o,
  output fp_dec_pkg::fp_fmt_e  fmt_o,
  output logic                 swap_operands_o,
  output logic                 mv_instr_o,
  output logic                 fp_load_o,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output fp_dec_pkg::mem_imm_e mem_imm_sel_o
);

  logic data_req;
  logic data_we;

  assign data_req = (fp_load_i | fp_store_i) & ~illegal_i;
  assign data_we  = fp_store_i & ~illegal_i;

  // Side effects killed for illegal words
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
      illegal_o   <= 1'b0;
      fp_rf_we_o  <= 1'b0;
      int_rf_we_o <= 1'b0;
      data_req_o  <= 1'b0;
      data_we_o   <= 1'b0;
    end else begin
      dec_valid_o <= valid_i;  // One-cycle strobe out
      if (valid_i) begin
        illegal_o   <= illegal_i;
        fp_rf_we_o  <= fp_rf_we_i & ~illegal_i;
        int_rf_we_o <= int_rf_we_i & ~illegal_i;
        data_req_o  <= data_req;
        data_we_o   <= data_we;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rs1_o           <= rs1_i;
      rs2_o           <= rs2_i;
      rs3_o           <= rs3_i;
      rd_o            <= rd_i;
      rounding_mode_o <= rounding_mode_i;
      rm_dynamic_o    <= rm_dynamic_i;
      use_rs1_o       <= use_rs1_i;
      use_rs2_o       <= use_rs2_i;
      use_rs3_o       <= use_rs3_i;
      use_rd_o        <= use_rd_i;
      fp_op_o         <= fp_op_i;
      fp_op_mod_o     <= fp_op_mod_i;
      fmt_o           <= fmt_i;
      swap_operands_o <= swap_operands_i;
      mv_instr_o      <= mv_instr_i;
      fp_load_o       <= fp_load_i;
      mem_imm_sel_o   <= mem_imm_sel_i;
    end
  end

endmodule

`default_nettype wire

//--- src/fp_decoder_top.sv
`default_nettype none

module fp_decoder_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 instr_valid_i,
  input  fp_dec_pkg::instr_t   instr_i,
  output logic                 dec_valid_o,
  output logic                 illegal_o,
  output fp_dec_pkg::reg_idx_t rs1_o,
  output fp_dec_pkg::reg_idx_t rs2_o,
  output fp_dec_pkg::reg_idx_t rs3_o,
  output fp_dec_pkg::reg_idx_t rd_o,
  output logic                 use_rs1_o,
  output logic                 use_rs2_o,
  output logic                 use_rs3_o,
  output logic                 use_rd_o,
  output logic                 fp_rf_we_o,
  output logic                 int_rf_we_o,
  output fp_dec_pkg::fp_op_e   fp_op_o,
  output logic                 fp_op_mod_o,
  output fp_dec_pkg::fp_fmt_e  fmt_o,
  output logic                 swap_operands_o,
  output logic                 mv_instr_o,
  output logic                 fp_load_o,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output fp_dec_pkg::mem_imm_e mem_imm_sel_o,
  output fp_dec_pkg::rm_t      rounding_mode_o,
  output logic                 rm_dynamic_o
);

  fp_dec_pkg::instr_t   instr_q;
  logic                 instr_vld_q;
  fp_dec_pkg::fp_op_e   dec_fp_op;
  logic                 dec_op_mod;
  fp_dec_pkg::fp_fmt_e  dec_fmt;
  logic                 dec_swap;
  logic                 dec_mv;
  logic                 dec_load;
  logic                 dec_store;
  fp_dec_pkg::mem_imm_e dec_imm_sel;
  logic                 dec_rm_dyn;
  logic                 dec_illegal;
  logic                 dec_use_rs1;
  logic                 dec_use_rs2;
  logic                 dec_use_rs3;
  logic                 dec_use_rd;
  logic                 dec_fp_we;
  logic                 dec_int_we;

  fp_instr_capture u_capture (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_o       (instr_q),
    .instr_valid_o (instr_vld_q)
  );

  fp_operation_decode u_op_decode (
    .instr_i         (instr_q),
    .fp_op_o         (dec_fp_op),
    .fp_op_mod_o     (dec_op_mod),
    .fmt_o           (dec_fmt),
    .swap_operands_o (dec_swap),
    .mv_instr_o      (dec_mv),
    .fp_load_o       (dec_load),
    .fp_store_o      (dec_store),
    .mem_imm_sel_o   (dec_imm_sel),
    .rm_dynamic_o    (dec_rm_dyn)
  );

  fp_legality_decode u_legality (
    .instr_i     (instr_q),
    .fmt_i       (dec_fmt),
    .illegal_o   (dec_illegal),
    .use_rs1_o   (dec_use_rs1),
    .use_rs2_o   (dec_use_rs2),
    .use_rs3_o   (dec_use_rs3),
    .use_rd_o    (dec_use_rd),
    .fp_rf_we_o  (dec_fp_we),
    .int_rf_we_o (dec_int_we)
  );

  // Register fields sliced straight from the captured word
  fp_decode_reg u_out_reg (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .valid_i         (instr_vld_q),
    .illegal_i       (dec_illegal),
    .rs1_i           (instr_q[19:15]),
    .rs2_i           (instr_q[24:20]),
    .rs3_i           (instr_q[31:27]),
    .rd_i            (instr_q[11:7]),
    .rounding_mode_i (instr_q[14:12]),
    .rm_dynamic_i    (dec_rm_dyn),
    .use_rs1_i       (dec_use_rs1),
    .use_rs2_i       (dec_use_rs2),
    .use_rs3_i       (dec_use_rs3),
    .use_rd_i        (dec_use_rd),
    .fp_rf_we_i      (dec_fp_we),
    .int_rf_we_i     (dec_int_we),
    .fp_op_i         (dec_fp_op),
    .fp_op_mod_i     (dec_op_mod),
    .fmt_i           (dec_fmt),
    .swap_operands_i (dec_swap),
    .mv_instr_i      (dec_mv),
    .fp_load_i       (dec_load),
    .fp_store_i      (dec_store),
    .mem_imm_sel_i   (dec_imm_sel),
    .dec_valid_o     (dec_valid_o),
    .illegal_o       (illegal_o),
    .rs1_o           (rs1_o),
    .rs2_o           (rs2_o),
    .rs3_o           (rs3_o),
    .rd_o            (rd_o),
    .rounding_mode_o (rounding_mode_o),
    .rm_dynamic_o    (rm_dynamic_o),
    .use_rs1_o       (use_rs1_o),
    .use_rs2_o       (use_rs2_o),
    .use_rs3_o       (use_rs3_o),
    .use_rd_o        (use_rd_o),
    .fp_rf_we_o      (fp_rf_we_o),
    .int_rf_we_o     (int_rf_we_o),
    .fp_op_o         (fp_op_o),
    .fp_op_mod_o     (fp_op_mod_o),
    .fmt_o           (fmt_o),
    .swap_operands_o (swap_operands_o),
    .mv_instr_o      (mv_instr_o),
    .fp_load_o       (fp_load_o),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .mem_imm_sel_o   (mem_imm_sel_o)
  );

endmodule

`default_nettype wire

//--- tests/fp_instr_builder.svh
`ifndef FP_INSTR_BUILDER_SVH
`define FP_INSTR_BUILDER_SVH

// OP-FP word with the format in the low funct7 bits
function automatic logic [31:0] encode_op_fp(input logic [6:0] funct7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] funct3,
                                             input logic [4:0] rd);
  encode_op_fp = {funct7, rs2, rs1, funct3, rd, 7'h53};
endfunction

// Fused multiply-add in the R4 layout with rs3 in the top bits
function automatic logic [31:0] encode_fma(input logic [6:0] opcode, input logic [4:0] rs3,
                                           input logic fmt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] rm,
                                           input logic [4:0] rd);
  encode_fma = {rs3, 1'b0, fmt, rs2, rs1, rm, rd, opcode};
endfunction

function automatic logic [31:0] encode_load(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] width, input logic [4:0] rd);
  encode_load = {imm, rs1, width, rd, 7'h07};
endfunction

// Store offset is split around the width field
function automatic logic [31:0] encode_store(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] width);
  encode_store = {imm[11:5], rs2, rs1, width, imm[4:0], 7'h27};
endfunction

// Any word under an arbitrary opcode for the illegal cases
function automatic logic [31:0] encode_raw(input logic [24:0] body, input logic [6:0] opcode);
  encode_raw = {body, opcode};
endfunction

`endif

//--- tests/tb_fp_decoder.sv
`default_nettype none

module tb_fp_decoder;
  timeunit 1ns;
  timeprecision 1ps;

  `include "fp_instr_builder.svh"

  logic clk_i;
  logic reset_i;
  logic instr_valid_i;
  logic [31:0] instr_i;
  logic dec_valid_o, illegal_o;
  fp_dec_pkg::reg_idx_t rs1_o, rs2_o, rs3_o, rd_o;
  logic use_rs1_o, use_rs2_o, use_rs3_o, use_rd_o;
  logic fp_rf_we_o, int_rf_we_o;
  fp_dec_pkg::fp_op_e fp_op_o;
  logic fp_op_mod_o;
  fp_dec_pkg::fp_fmt_e fmt_o;
  logic swap_operands_o, mv_instr_o, fp_load_o, data_req_o, data_we_o;
  fp_dec_pkg::mem_imm_e mem_imm_sel_o;
  fp_dec_pkg::rm_t rounding_mode_o;
  logic rm_dynamic_o;

  int unsigned rng_state = 32'd61826;
  int checks = 0;
  int errors = 0;

  fp_decoder_top u_fp_decoder_top (
    .clk_i (clk_i), .reset_i (reset_i), .instr_valid_i (instr_valid_i), .instr_i (instr_i),
    .dec_valid_o (dec_valid_o), .illegal_o (illegal_o),
    .rs1_o (rs1_o), .rs2_o (rs2_o), .rs3_o (rs3_o), .rd_o (rd_o),
    .use_rs1_o (use_rs1_o), .use_rs2_o (use_rs2_o), .use_rs3_o (use_rs3_o),
    .use_rd_o (use_rd_o), .fp_rf_we_o (fp_rf_we_o), .int_rf_we_o (int_rf_we_o),
    .fp_op_o (fp_op_o), .fp_op_mod_o (fp_op_mod_o), .fmt_o (fmt_o),
    .swap_operands_o (swap_operands_o), .mv_instr_o (mv_instr_o), .fp_load_o (fp_load_o),
    .data_req_o (data_req_o), .data_we_o (data_we_o), .mem_imm_sel_o (mem_imm_sel_o),
    .rounding_mode_o (rounding_mode_o), .rm_dynamic_o (rm_dynamic_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [4:0] random_reg();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    random_reg = rng_state[4:0];
  endfunction

  task automatic check_field(input string test, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("MISMATCH %s %s expected %0h actual %0h", test, field, exp, act);
      errors++;
    end
  endtask

  // Strobe one word, then poll for the result strobe
  task automatic issue_and_wait(input string test, input logic [31:0] word);
    int n;
    instr_valid_i = 1'b1;
    instr_i = word;
    @(posedge clk_i);
    #2;
    instr_valid_i = 1'b0;
    for (n = 0; n < 10; n++) begin
      if (dec_valid_o) break;
      @(posedge clk_i);
      #2;
    end
    if (!dec_valid_o) begin
      $display("%s timed out waiting for dec_valid_o", test);
      errors++;
    end
  endtask

  task automatic report(input string test, input int errors_before);
    $display("%s finished with %0d errors", test, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_arith();
    logic [6:0] f7 [5] = '{7'b0000000, 7'b0000101, 7'b0001000, 7'b0001101, 7'b0101100};
    fp_dec_pkg::fp_op_e ops [5] = '{fp_dec_pkg::ADD, fp_dec_pkg::ADD, fp_dec_pkg::MUL,
                                     fp_dec_pkg::DIV, fp_dec_pkg::SQRT};
    logic mods [5] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    logic swaps [5] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    logic [4:0] rs1, rs2, rd;
    int e0;
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      rs1 = random_reg();
      rs2 = (i == 4) ? 5'd0 : random_reg();  // Square root needs rs2 zero
      rd = random_reg();
      issue_and_wait("arith", encode_op_fp(f7[i], rs2, rs1, 3'b000, rd));
      check_field("arith", "fp_op", 32'(ops[i]), 32'(fp_op_o));
      check_field("arith", "mod", 32'(mods[i]), 32'(fp_op_mod_o));
      check_field("arith", "fmt", 32'(f7[i][0]), 32'(fmt_o));
      check_field("arith", "swap", 32'(swaps[i]), 32'(swap_operands_o));
      check_field("arith", "use_rs1", 32'(1), 32'(use_rs1_o));
      check_field("arith", "use_rs2", 32'(i != 4), 32'(use_rs2_o));
      check_field("arith", "use_rs3", 32'(0), 32'(use_rs3_o));
      check_field("arith", "use_rd", 32'(1), 32'(use_rd_o));
      check_field("arith", "fp_rf_we", 32'(1), 32'(fp_rf_we_o));
      check_field("arith", "rounding_mode", 32'(0), 32'(rounding_mode_o));
      check_field("arith", "rm_dynamic", 32'(0), 32'(rm_dynamic_o));
      check_field("arith", "rs1", 32'(rs1), 32'(rs1_o));
      check_field("arith", "rs2", 32'(rs2), 32'(rs2_o));
      check_field("arith", "rd", 32'(rd), 32'(rd_o));
    end
    report("arith", e0);
  endtask

  task automatic test_fma();
    logic [6:0] opc [4] = '{7'h43, 7'h47, 7'h4b, 7'h4f};
    fp_dec_pkg::fp_op_e ops [4] = '{fp_dec_pkg::FMADD, fp_dec_pkg::FMADD,
                                     fp_dec_pkg::FNMSUB, fp_dec_pkg::FNMSUB};
    logic mods [4] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic [4:0] rs3;
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      rs3 = random_reg();
      issue_and_wait("fma", encode_fma(opc[i / 2], rs3, i[0], random_reg(), random_reg(),
                                       3'b000, random_reg()));
      check_field("fma", "fp_op", 32'(ops[i / 2]), 32'(fp_op_o));
      check_field("fma", "mod", 32'(mods[i / 2]), 32'(fp_op_mod_o));
      check_field("fma", "fmt", 32'(i[0]), 32'(fmt_o));
      check_field("fma", "use_rs3", 32'(1), 32'(use_rs3_o));
      check_field("fma", "rs3", 32'(rs3), 32'(rs3_o));
      check_field("fma", "fp_rf_we", 32'(1), 32'(fp_rf_we_o));
    end
    report("fma", e0);
  endtask

  task automatic test_memory();
    logic store;
    logic dbl;
    int e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      store = i[1];
      dbl = i[0];
      if (store) begin
        issue_and_wait("memory", encode_store(12'h4c, random_reg(), random_reg(), {2'b01, dbl}));
      end else begin
        issue_and_wait("memory", encode_load(12'h10, random_reg(), {2'b01, dbl}, random_reg()));
      end
      check_field("memory", "data_req", 32'(1), 32'(data_req_o));
      check_field("memory", "data_we", 32'(store), 32'(data_we_o));
      check_field("memory", "fp_load", 32'(!store), 32'(fp_load_o));
      check_field("memory", "imm_sel", 32'(store), 32'(mem_imm_sel_o));
      check_field("memory", "fmt", 32'(dbl), 32'(fmt_o));
      check_field("memory", "fp_rf_we", 32'(!store), 32'(fp_rf_we_o));
      check_field("memory", "int_rf_we", 32'(0), 32'(int_rf_we_o));
    end
    report("memory", e0);
  endtask

  task automatic test_int_side();
    int e0;
    e0 = errors;
    issue_and_wait("int_side", encode_op_fp(7'b1010000, random_reg(), random_reg(), 3'b010, 5'd3));
    check_field("int_side", "fp_op", 32'(fp_dec_pkg::CMP), 32'(fp_op_o));
    check_field("int_side", "int_rf_we", 32'(1), 32'(int_rf_we_o));
    issue_and_wait("int_side", encode_op_fp(7'b1110000, 5'd0, random_reg(), 3'b001, 5'd4));
    check_field("int_side", "fp_op", 32'(fp_dec_pkg::CLASSIFY), 32'(fp_op_o));
    check_field("int_side", "mv_instr", 32'(0), 32'(mv_instr_o));
    check_field("int_side", "int_rf_we", 32'(1), 32'(int_rf_we_o));
    issue_and_wait("int_side", encode_op_fp(7'b1110000, 5'd0, random_reg(), 3'b000, 5'd5));
    check_field("int_side", "mv_instr", 32'(1), 32'(mv_instr_o));
    check_field("int_side", "int_rf_we", 32'(1), 32'(int_rf_we_o));
    check_field("int_side", "fp_rf_we", 32'(0), 32'(fp_rf_we_o));
    for (int u = 0; u < 2; u++) begin
      // FCVT.W.S then FCVT.WU.S with a dynamic rounding mode
      issue_and_wait("int_side", encode_op_fp(7'b1100000, 5'(u), random_reg(), 3'b111, 5'd6));
      check_field("int_side", "fp_op", 32'(fp_dec_pkg::F2I), 32'(fp_op_o));
      check_field("int_side", "mod", 32'(u), 32'(fp_op_mod_o));
      check_field("int_side", "rounding_mode", 32'(3'b111), 32'(rounding_mode_o));
      check_field("int_side", "rm_dynamic", 32'(1), 32'(rm_dynamic_o));
      check_field("int_side", "int_rf_we", 32'(1), 32'(int_rf_we_o));
      check_field("int_side", "illegal", 32'(0), 32'(illegal_o));
    end
    report("int_side", e0);
  endtask

  task automatic test_illegal();
    logic [31:0] words [5];
    int e0;
    e0 = errors;
    words[0] = encode_op_fp(7'b0000000, 5'd1, 5'd2, 3'b101, 5'd3);
    words[1] = encode_op_fp(7'b0000010, 5'd1, 5'd2, 3'b000, 5'd3);
    words[2] = encode_raw(25'h12345, 7'h33);
    words[3] = encode_op_fp(7'b0101100, 5'd3, 5'd2, 3'b000, 5'd3);
    words[4] = encode_load(12'h0, 5'd2, 3'b000, 5'd3);
    for (int i = 0; i < 5; i++) begin
      issue_and_wait("illegal", words[i]);
      check_field("illegal", "illegal", 32'(1), 32'(illegal_o));
      check_field("illegal", "fp_rf_we", 32'(0), 32'(fp_rf_we_o));
      check_field("illegal", "int_rf_we", 32'(0), 32'(int_rf_we_o));
      check_field("illegal", "data_req", 32'(0), 32'(data_req_o));
      check_field("illegal", "data_we", 32'(0), 32'(data_we_o));
    end
    report("illegal", e0);
  endtask

  // Word c is sampled at edge c+1 and its result seen after edge c+2
  task automatic test_pipeline();
    logic [4:0] rd [6];
    int e0;
    e0 = errors;
    for (int i = 0; i < 6; i++) rd[i] = random_reg();
    @(posedge clk_i);  // Let the previous result strobe drop
    #2;
    for (int c = 0; c < 13; c++) begin
      check_field("pipeline", "dec_valid", 32'(c >= 2 && c < 8), 32'(dec_valid_o));
      if (c >= 2 && c < 8) begin
        check_field("pipeline", "rd", 32'(rd[c - 2]), 32'(rd_o));
        check_field("pipeline", "fp_op",
                    32'((c - 2) % 2 == 0 ? fp_dec_pkg::MUL : fp_dec_pkg::DIV), 32'(fp_op_o));
      end
      instr_valid_i = (c < 6);
      if (c < 6) begin
        instr_i = encode_op_fp((c % 2 == 0) ? 7'b0001000 : 7'b0001100, 5'd1, 5'd2, 3'b000,
                               rd[c]);
      end
      @(posedge clk_i);
      #2;
    end
    report("pipeline", e0);
  endtask

  initial begin
    reset_i = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    check_field("reset", "dec_valid", 32'(0), 32'(dec_valid_o));
    check_field("reset", "illegal", 32'(0), 32'(illegal_o));
    check_field("reset", "fp_rf_we", 32'(0), 32'(fp_rf_we_o));
    check_field("reset", "int_rf_we", 32'(0), 32'(int_rf_we_o));
    check_field("reset", "data_req", 32'(0), 32'(data_req_o));
    check_field("reset", "data_we", 32'(0), 32'(data_we_o));
    test_arith();
    test_fma();
    test_memory();
    test_int_side();
    test_illegal();
    test_pipeline();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tests
src/fp_dec_pkg.sv
src/fp_instr_capture.sv
src/fp_operation_decode.sv
src/fp_legality_decode.sv
src/fp_decode_reg.sv
src/fp_decoder_top.sv
tests/tb_fp_decoder.sv

//--- Makefile
TOP := tb_fp_decoder

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f src/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
